// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
TOP        = tb_branch_predictor
FILELIST   = branch_predictor.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bht_history_table.sv
`timescale 1ns/1ps

module bht_history_table
    import bp_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // prediction lookups, one per issue slot
    input  bht_idx_t idx_0,
    input  bht_idx_t idx_1,

    // resolved branch from dispatch
    input  bht_idx_t idx_upd,
    input  logic     update_en,
    input  logic     taken_actual,

    output history_t hist_0,
    output history_t hist_1,
    output history_t hist_upd
);

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    // one local history per branch slot, newest outcome in bit 0
    history_t bht [BHT_DEPTH];

    // shifted history for the entry being trained
    history_t hist_next;

    //////////////////////////////////////////////////////////////////////
    // read ports
    //////////////////////////////////////////////////////////////////////

    // all three reads are asynchronous and see the contents from before
    // this cycle's edge, so a same-cycle update is not visible yet
    assign hist_0 = bht[idx_0];
    assign hist_1 = bht[idx_1];

    // dispatch read feeds both the shift below and the pht training
    assign hist_upd = bht[idx_upd];

    //////////////////////////////////////////////////////////////////////
    // update port
    //////////////////////////////////////////////////////////////////////

    // oldest outcome drops off the top
    assign hist_next = {hist_upd[HIST_W-2:0], taken_actual};

    always_ff @(posedge clk) begin
        if (rst) begin
            bht <= '{default: '0};
        end else if (update_en) begin
            bht[idx_upd] <= hist_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // dispatch must present a clean branch whenever it strobes an update,
    // otherwise both tables train on garbage at the same edge
    a_upd_known: assert property (
        @(posedge clk) disable iff (rst)
        update_en |-> !$isunknown({taken_actual, idx_upd})
    ) else $error("bht update with unknown index or outcome");

endmodule

// File: bp_pkg.sv
package bp_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and positions
    //////////////////////////////////////////////////////////////////////

    // fetch and dispatch address width
    localparam int ADDR_W = 32;

    // issue slots per fetch cycle
    localparam int FETCH_W = 2;

    // local history length, also the pht column select
    localparam int HIST_W = 8;

    // table index comes from word-aligned address bits
    localparam int IDX_LSB = 2;
    localparam int IDX_W = 8;

    //////////////////////////////////////////////////////////////////////
    // table sizes
    //////////////////////////////////////////////////////////////////////

    localparam int BHT_DEPTH = 1 << IDX_W;

    // row is history xor index, so both must share one width
    localparam int PHT_ROWS = 1 << IDX_W;
    localparam int PHT_COLS = 1 << HIST_W;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef logic [ADDR_W-1:0] inst_addr_t;
    typedef logic [IDX_W-1:0]  bht_idx_t;
    typedef logic [HIST_W-1:0] history_t;
    typedef logic [1:0]        counter_t;

    // counter encodings, upper bit set means predict taken
    localparam counter_t CTR_RESET = 2'd0;
    localparam counter_t CTR_MAX   = 2'd3;

endpackage

// File: branch_predictor.f
bp_pkg.sv
bht_history_table.sv
pht_counter_table.sv
branch_predictor.sv
tb_clock_gen.sv
tb_branch_predictor.sv

// File: branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor
    import bp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // fetch addresses, one per issue slot
    input  inst_addr_t pc_0,
    input  inst_addr_t pc_1,

    // resolved branch, held valid while update_en is high
    input  logic       update_en,
    input  inst_addr_t pc_dispatch,
    input  logic       taken_actual,

    // registered direction, one cycle after the fetch addresses
    output logic       taken_0,
    output logic       taken_1
);

    //////////////////////////////////////////////////////////////////////
    // index slicing
    //////////////////////////////////////////////////////////////////////

    bht_idx_t idx_0;
    bht_idx_t idx_1;
    bht_idx_t idx_upd;

    // word aligned, low two bits carry nothing
    assign idx_0   = pc_0[IDX_LSB +: IDX_W];
    assign idx_1   = pc_1[IDX_LSB +: IDX_W];
    assign idx_upd = pc_dispatch[IDX_LSB +: IDX_W];

    //////////////////////////////////////////////////////////////////////
    // first level, local histories
    //////////////////////////////////////////////////////////////////////

    history_t hist_0;
    history_t hist_1;
    history_t hist_upd;

    bht_history_table u_bht (
        .clk          (clk),
        .rst          (rst),
        .idx_0        (idx_0),
        .idx_1        (idx_1),
        .idx_upd      (idx_upd),
        .update_en    (update_en),
        .taken_actual (taken_actual),
        .hist_0       (hist_0),
        .hist_1       (hist_1),
        .hist_upd     (hist_upd)
    );

    //////////////////////////////////////////////////////////////////////
    // second level, pattern counters
    //////////////////////////////////////////////////////////////////////

    pht_counter_table u_pht (
        .clk          (clk),
        .rst          (rst),
        .idx_0        (idx_0),
        .idx_1        (idx_1),
        .hist_0       (hist_0),
        .hist_1       (hist_1),
        .idx_upd      (idx_upd),
        .hist_upd     (hist_upd),
        .update_en    (update_en),
        .taken_actual (taken_actual),
        .taken_0      (taken_0),
        .taken_1      (taken_1)
    );

endmodule

// File: pht_counter_table.sv
`timescale 1ns/1ps

module pht_counter_table
    import bp_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // prediction side, index and history per issue slot
    input  bht_idx_t idx_0,
    input  bht_idx_t idx_1,
    input  history_t hist_0,
    input  history_t hist_1,

    // training side
    input  bht_idx_t idx_upd,
    input  history_t hist_upd,
    input  logic     update_en,
    input  logic     taken_actual,

    output logic     taken_0,
    output logic     taken_1
);

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    // row is history xor address index, column is the raw history
    counter_t pht [PHT_ROWS][PHT_COLS];

    //////////////////////////////////////////////////////////////////////
    // saturating step
    //////////////////////////////////////////////////////////////////////

    // one step toward the outcome, sticks at zero and CTR_MAX
    function automatic counter_t ctr_step(input counter_t ctr, input logic up);
        counter_t nxt;
        nxt = ctr;
        if (up) begin
            if (ctr != CTR_MAX) begin
                nxt = ctr + 1'b1;
            end
        end else begin
            if (ctr != '0) begin
                nxt = ctr - 1'b1;
            end
        end
        return nxt;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // prediction ports
    //////////////////////////////////////////////////////////////////////

    bht_idx_t pred_idx  [FETCH_W];
    history_t pred_hist [FETCH_W];
    counter_t pred_ctr  [FETCH_W];

    // registered taken bits, one per slot
    logic [FETCH_W-1:0] pred_q;

    assign pred_idx[0]  = idx_0;
    assign pred_idx[1]  = idx_1;
    assign pred_hist[0] = hist_0;
    assign pred_hist[1] = hist_1;

    for (genvar p = 0; p < FETCH_W; p++) begin : g_pred
        bht_idx_t pred_row;

        // hashed row spreads branches sharing a history
        assign pred_row    = pred_hist[p] ^ pred_idx[p];
        assign pred_ctr[p] = pht[pred_row][pred_hist[p]];
    end

    // counter msb is the direction, weak and strong states agree
    always_ff @(posedge clk) begin
        if (rst) begin
            pred_q <= '0;
        end else begin
            for (int p = 0; p < FETCH_W; p++) begin
                pred_q[p] <= pred_ctr[p][$bits(counter_t)-1];
            end
        end
    end

    assign taken_0 = pred_q[0];
    assign taken_1 = pred_q[1];

    //////////////////////////////////////////////////////////////////////
    // training
    //////////////////////////////////////////////////////////////////////

    bht_idx_t upd_row;
    counter_t upd_ctr;
    counter_t upd_ctr_next;

    // same hash as the prediction side, using the pre-shift history
    assign upd_row      = hist_upd ^ idx_upd;
    assign upd_ctr      = pht[upd_row][hist_upd];
    assign upd_ctr_next = ctr_step(upd_ctr, taken_actual);

    // written at the strobe edge, so a prediction in the same cycle
    // still reads the old counter
    always_ff @(posedge clk) begin
        if (rst) begin
            pht <= '{default: CTR_RESET};
        end else if (update_en) begin
            pht[upd_row][hist_upd] <= upd_ctr_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // an x on a prediction means an unknown history or index reached the
    // table from the history side or the fetch addresses
    a_pred_known: assert property (
        @(posedge clk) !rst |-> !$isunknown({taken_0, taken_1})
    ) else $error("prediction unknown out of reset");

endmodule

// File: tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor
    import bp_pkg::*;
();

    //////////////////////////////////////////////////////////////////////
    // run lengths in cycles
    //////////////////////////////////////////////////////////////////////

    localparam int RST_CYCLES = 5;
    localparam int LEN_RESET  = 16;
    localparam int LEN_TRAIN  = 25;
    localparam int LEN_HYST   = 51;
    localparam int LEN_PORTS  = 16;
    localparam int LEN_SAME   = 11;
    localparam int LEN_RANDOM = 2000;
    localparam int MARGIN     = 100;
    localparam int TIMEOUT_CYCLES = RST_CYCLES + LEN_RESET + LEN_TRAIN + LEN_HYST
                                  + LEN_PORTS + LEN_SAME + LEN_RANDOM + MARGIN;

    // branches with distinct history slots
    localparam inst_addr_t BR_TRAIN = 32'h0000_0140;
    localparam inst_addr_t BR_HYST  = 32'h0000_0a80;
    localparam inst_addr_t BR_SAME  = 32'h0000_0300;

    // small pool where some entries share a history slot through upper bits
    localparam inst_addr_t POOL [8] = '{
        BR_TRAIN, BR_HYST, BR_SAME, 32'h0010_0140,
        32'h0000_0144, 32'h0000_0a84, 32'h0000_1300, 32'h0000_0004
    };

    logic       clk;
    logic       rst;
    inst_addr_t pc_0;
    inst_addr_t pc_1;
    inst_addr_t pc_dispatch;
    logic       update_en;
    logic       taken_actual;
    logic       taken_0;
    logic       taken_1;

    tb_clock_gen #(.PERIOD(10), .RST_CYCLES(RST_CYCLES)) u_clk (
        .clk (clk),
        .rst (rst)
    );

    branch_predictor uut (
        .clk          (clk),
        .rst          (rst),
        .pc_0         (pc_0),
        .pc_1         (pc_1),
        .update_en    (update_en),
        .pc_dispatch  (pc_dispatch),
        .taken_actual (taken_actual),
        .taken_0      (taken_0),
        .taken_1      (taken_1)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    history_t ref_bht [256];
    counter_t ref_pht [256][256];

    // captured at the rising edge, compared at the falling edge
    logic       exp_valid = 1'b0;
    logic [1:0] exp_taken;
    string      exp_name;
    logic       exp_rule_valid;
    logic       exp_rule;

    // extra expectation on slot 0 worked out by hand
    string test_name;
    logic  rule_valid;
    logic  rule_taken;

    int     total_checks = 0;
    int     total_errors = 0;
    int     cycle_count  = 0;
    int     err_base;
    int     chk_base;
    int     tests_passed;
    int     tests_failed;
    integer seed;

    function automatic logic predict_one(inst_addr_t a);
        logic [7:0] idx;
        history_t   h;
        counter_t   c;
        idx = a[9:2];
        h   = ref_bht[idx];
        c   = ref_pht[h ^ idx][h];
        return c[1];
    endfunction

    function automatic logic [1:0] expected_pair(inst_addr_t a0, inst_addr_t a1);
        return {predict_one(a1), predict_one(a0)};
    endfunction

    task automatic train_model(inst_addr_t a, logic t);
        logic [7:0] idx;
        history_t   h;
        counter_t   c;
        idx = a[9:2];
        h   = ref_bht[idx];
        c   = ref_pht[h ^ idx][h];
        if (t && c < 2'd3) begin
            c = c + 2'd1;
        end else if (!t && c > 2'd0) begin
            c = c - 2'd1;
        end
        ref_pht[h ^ idx][h] = c;
        ref_bht[idx]        = {h[6:0], t};
    endtask

    task automatic clear_model();
        for (int r = 0; r < 256; r++) begin
            ref_bht[r] = '0;
            for (int c = 0; c < 256; c++) begin
                ref_pht[r][c] = 2'd0;
            end
        end
    endtask

    // predictions read the tables before this edge's update
    always @(posedge clk) begin
        if (rst) begin
            clear_model();
            exp_taken = 2'b00;
        end else begin
            exp_taken = expected_pair(pc_0, pc_1);
            if (update_en) begin
                train_model(pc_dispatch, taken_actual);
            end
        end
        exp_name       = test_name;
        exp_rule_valid = rule_valid;
        exp_rule       = rule_taken;
        exp_valid      = 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // comparison
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(string name, logic expected, logic actual);
        total_checks++;
        if (actual !== expected) begin
            total_errors++;
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    always @(negedge clk) begin
        if (exp_valid) begin
            check_value({exp_name, " slot 0"}, exp_taken[0], taken_0);
            check_value({exp_name, " slot 1"}, exp_taken[1], taken_1);
            if (exp_rule_valid) begin
                check_value({exp_name, " rule"}, exp_rule, taken_0);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, run still going after %0d cycles", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic drive_cycle(inst_addr_t a0, inst_addr_t a1, logic upd,
                               inst_addr_t ad, logic t);
        @(negedge clk);
        pc_0         = a0;
        pc_1         = a1;
        update_en    = upd;
        pc_dispatch  = ad;
        taken_actual = t;
        rule_valid   = 1'b0;
    endtask

    task automatic expect_rule(logic t);
        rule_valid = 1'b1;
        rule_taken = t;
    endtask

    // bit 10 flip keeps the history slot, so slot 1 aliases slot 0
    task automatic run_updates(inst_addr_t a, logic t, int n);
        for (int i = 0; i < n; i++) begin
            drive_cycle(a, a ^ 32'h0000_0400, 1'b1, a, t);
        end
    endtask

    // last driven cycle gets compared at this falling edge
    task automatic settle();
        @(negedge clk);
        update_en  = 1'b0;
        rule_valid = 1'b0;
        #1;
    endtask

    task automatic start_test(string name);
        test_name = name;
        err_base  = total_errors;
        chk_base  = total_checks;
    endtask

    task automatic finish_test();
        int errs;
        errs = total_errors - err_base;
        if (errs == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("%s: %s, %0d checks, %0d mismatches", test_name,
                 (errs == 0) ? "passed" : "failed", total_checks - chk_base, errs);
    endtask

    initial begin
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        seed         = 1;
        tests_passed = 0;
        tests_failed = 0;
        pc_0         = '0;
        pc_1         = '0;
        pc_dispatch  = '0;
        update_en    = 1'b0;
        taken_actual = 1'b0;
        rule_valid   = 1'b0;
        rule_taken   = 1'b0;
        test_name    = "reset";
        while (rst !== 1'b0) @(posedge clk);

        start_test("reset_state");
        for (int i = 0; i < LEN_RESET; i++) begin
            r0 = $random(seed);
            r1 = $random(seed);
            drive_cycle(r0, r1, 1'b0, '0, 1'b0);
            expect_rule(1'b0);
        end
        settle();
        finish_test();

        // history fills with ones, then its counter climbs past the midpoint
        start_test("train_taken");
        run_updates(BR_TRAIN, 1'b1, LEN_TRAIN - 1);
        drive_cycle(BR_TRAIN, BR_TRAIN + 32'd4, 1'b0, BR_TRAIN, 1'b0);
        expect_rule(1'b1);
        settle();
        finish_test();

        start_test("hysteresis");
        run_updates(BR_HYST, 1'b1, 20);
        run_updates(BR_HYST, 1'b0, 1);
        // eight taken bring the all ones history back, its counter is now 2
        run_updates(BR_HYST, 1'b1, 8);
        drive_cycle(BR_HYST, BR_HYST, 1'b0, BR_HYST, 1'b0);
        expect_rule(1'b1);
        run_updates(BR_HYST, 1'b0, 20);
        drive_cycle(BR_HYST, BR_HYST, 1'b0, BR_HYST, 1'b0);
        expect_rule(1'b0);
        settle();
        finish_test();

        start_test("dual_port");
        drive_cycle(BR_TRAIN, BR_HYST, 1'b0, '0, 1'b0);
        drive_cycle(BR_HYST, BR_TRAIN, 1'b0, '0, 1'b0);
        drive_cycle(BR_TRAIN, BR_TRAIN, 1'b0, '0, 1'b0);
        drive_cycle(BR_TRAIN, BR_TRAIN ^ 32'h8000_0000, 1'b0, '0, 1'b0);
        for (int i = 0; i < LEN_PORTS - 4; i++) begin
            r0 = $random(seed);
            drive_cycle(POOL[r0[2:0]], POOL[r0[6:4]], 1'b0, '0, 1'b0);
        end
        settle();
        finish_test();

        // full history with its counter at weakly not taken
        start_test("same_cycle");
        run_updates(BR_SAME, 1'b1, 9);
        drive_cycle(BR_SAME, BR_SAME, 1'b1, BR_SAME, 1'b1);
        expect_rule(1'b0);
        drive_cycle(BR_SAME, BR_SAME, 1'b0, BR_SAME, 1'b0);
        expect_rule(1'b1);
        settle();
        finish_test();

        start_test("random_mix");
        for (int i = 0; i < LEN_RANDOM; i++) begin
            r0 = $random(seed);
            r1 = $random(seed);
            r2 = $random(seed);
            drive_cycle(POOL[r0[2:0]], POOL[r1[2:0]], r2[0], POOL[r2[6:4]],
                        r2[9:8] != 2'b00);
        end
        settle();
        finish_test();

        $display("%0d tests passed, %0d tests failed, %0d checks, %0d mismatches",
                 tests_passed, tests_failed, total_checks, total_errors);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD     = 10,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule
